/* rtl/lbm_params.svh */
`ifndef LBM_PARAMS_SVH
`define LBM_PARAMS_SVH

// grid geometry
`define LBM_WIDTH 4
`define LBM_HEIGHT 4
`define LBM_DEPTH 16
`define LBM_ADDR_WIDTH 4

// population word and lattice directions
`define LBM_DATA_WIDTH 16
`define LBM_DIRS 9

`endif

/* rtl/lbm_pkg.sv */
`include "lbm_params.svh"

package lbm_pkg;

    typedef logic [`LBM_DATA_WIDTH-1:0] dist_t;
    // row * width + column
    typedef logic [`LBM_ADDR_WIDTH-1:0] addr_t;
    typedef logic [$clog2(`LBM_WIDTH)-1:0] col_t;
    typedef logic [$clog2(`LBM_HEIGHT)-1:0] row_t;

    // north lowers the row, east raises the column
    typedef enum logic [3:0] {
        DIR_REST,
        DIR_N,
        DIR_NE,
        DIR_E,
        DIR_SE,
        DIR_S,
        DIR_SW,
        DIR_W,
        DIR_NW
    } dir_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SWEEP,
        ST_DRAIN
    } sweep_state_t;

    function automatic logic signed [1:0] dir_dx(dir_t d);
        case (d)
            DIR_NE, DIR_E, DIR_SE: return 2'sd1;
            DIR_SW, DIR_W, DIR_NW: return -2'sd1;
            default: return 2'sd0;
        endcase
    endfunction

    function automatic logic signed [1:0] dir_dy(dir_t d);
        case (d)
            DIR_SE, DIR_S, DIR_SW: return 2'sd1;
            DIR_N, DIR_NE, DIR_NW: return -2'sd1;
            default: return 2'sd0;
        endcase
    endfunction

    // moving directions sit in a ring of eight, opposite is four steps round
    function automatic dir_t opposite_dir(dir_t d);
        if (d == DIR_REST)
            return DIR_REST;
        return dir_t'((d > 4) ? d - 4 : d + 4);
    endfunction

endpackage

/* rtl/lattice_ram.sv */
`timescale 1ns/10ps
`include "lbm_params.svh"

module lattice_ram (
    input  logic           clk,
    input  lbm_pkg::addr_t read_addr,
    output lbm_pkg::dist_t read_data,
    input  logic           write_en,
    input  lbm_pkg::addr_t write_addr,
    input  lbm_pkg::dist_t write_data
);

    lbm_pkg::dist_t mem [`LBM_DEPTH];

    // registered read, one write per clock
    always_ff @(posedge clk)
    begin
        if (write_en)
            mem[write_addr] <= write_data;
        read_data <= mem[read_addr];
    end

endmodule

/* rtl/sweep_ctrl.sv */
`timescale 1ns/10ps
`include "lbm_params.svh"

module sweep_ctrl (
    input  logic           clk,
    input  logic           rst,
    input  logic           start,
    input  lbm_pkg::addr_t host_addr,
    output logic           busy,
    output logic           done,
    output lbm_pkg::addr_t src_addr,
    output lbm_pkg::col_t  src_col,
    output lbm_pkg::row_t  src_row,
    output logic           read_valid,
    output logic           write_valid,
    output logic           buf_sel
);

    lbm_pkg::sweep_state_t state;
    // bank data returning for the cell read last cycle
    logic data_valid;
    logic last_col;
    logic last_cell;

    assign last_col = (src_col == lbm_pkg::col_t'(`LBM_WIDTH - 1));
    assign last_cell = last_col && (src_row == lbm_pkg::row_t'(`LBM_HEIGHT - 1));

    assign busy = (state != lbm_pkg::ST_IDLE);
    assign read_valid = (state == lbm_pkg::ST_SWEEP);

    // host owns the read address between steps
    assign src_addr = (state == lbm_pkg::ST_IDLE) ? host_addr
                    : lbm_pkg::addr_t'(src_row * `LBM_WIDTH + src_col);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state <= lbm_pkg::ST_IDLE;
            src_col <= '0;
            src_row <= '0;
            data_valid <= 1'b0;
            write_valid <= 1'b0;
            buf_sel <= 1'b0;
            done <= 1'b0;
        end
        else
        begin
            data_valid <= read_valid;
            write_valid <= data_valid;
            done <= 1'b0;
            case (state)
                lbm_pkg::ST_IDLE:
                begin
                    if (start)
                    begin
                        state <= lbm_pkg::ST_SWEEP;
                        src_col <= '0;
                        src_row <= '0;
                    end
                end
                lbm_pkg::ST_SWEEP:
                begin
                    if (last_cell)
                    begin
                        src_col <= '0;
                        src_row <= '0;
                        state <= lbm_pkg::ST_DRAIN;
                    end
                    else if (last_col)
                    begin
                        src_col <= '0;
                        src_row <= src_row + 1'b1;
                    end
                    else
                        src_col <= src_col + 1'b1;
                end
                lbm_pkg::ST_DRAIN:
                begin
                    // only the final write is left once the data stage is empty
                    if (!data_valid)
                    begin
                        state <= lbm_pkg::ST_IDLE;
                        buf_sel <= ~buf_sel;
                        done <= 1'b1;
                    end
                end
                default:
                    state <= lbm_pkg::ST_IDLE;
            endcase
        end
    end

endmodule

/* rtl/stream_lane.sv */
`timescale 1ns/10ps
`include "lbm_params.svh"

module stream_lane #(
    parameter lbm_pkg::dir_t DIR = lbm_pkg::DIR_REST
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`LBM_DEPTH-1:0] barriers,
    input  lbm_pkg::addr_t        src_addr,
    input  lbm_pkg::col_t         src_col,
    input  lbm_pkg::row_t         src_row,
    input  logic                  read_valid,
    input  logic                  write_valid,
    input  logic                  buf_sel,
    input  lbm_pkg::dist_t        opp_word,
    input  logic                  host_we,
    input  lbm_pkg::dist_t        host_data,
    output lbm_pkg::dist_t        rd_word
);

    localparam int DX = lbm_pkg::dir_dx(DIR);
    localparam int DY = lbm_pkg::dir_dy(DIR);

    lbm_pkg::col_t  tgt_col;
    lbm_pkg::row_t  tgt_row;
    // stage 1, alongside the bank read
    lbm_pkg::addr_t tgt_addr_q;
    logic           src_bar_q;
    // stage 2, feeding the next-buffer write
    lbm_pkg::addr_t wr_addr_q;
    lbm_pkg::dist_t wr_data_q;
    lbm_pkg::dist_t bank_rd [2];

    // neighbour cell on a torus
    always_comb
    begin
        if (DX > 0)
            tgt_col = (src_col == lbm_pkg::col_t'(`LBM_WIDTH - 1)) ? '0 : src_col + 1'b1;
        else if (DX < 0)
            tgt_col = (src_col == '0) ? lbm_pkg::col_t'(`LBM_WIDTH - 1) : src_col - 1'b1;
        else
            tgt_col = src_col;

        if (DY > 0)
            tgt_row = (src_row == lbm_pkg::row_t'(`LBM_HEIGHT - 1)) ? '0 : src_row + 1'b1;
        else if (DY < 0)
            tgt_row = (src_row == '0) ? lbm_pkg::row_t'(`LBM_HEIGHT - 1) : src_row - 1'b1;
        else
            tgt_row = src_row;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            tgt_addr_q <= '0;
            src_bar_q <= 1'b0;
        end
        else if (read_valid)
        begin
            tgt_addr_q <= lbm_pkg::addr_t'(tgt_row * `LBM_WIDTH + tgt_col);
            src_bar_q <= barriers[src_addr];
        end
    end

    // barrier target wins over reflection from a barrier source
    always_ff @(posedge clk)
    begin
        wr_addr_q <= tgt_addr_q;
        if (barriers[tgt_addr_q])
            wr_data_q <= '0;
        else if (src_bar_q)
            wr_data_q <= opp_word;
        else
            wr_data_q <= rd_word;
    end

    for (genvar b = 0; b < 2; b++)
    begin : g_bank
        // bank b holds the current step when buf_sel equals b
        logic is_cur;

        assign is_cur = (buf_sel == 1'(b));

        lattice_ram i_ram (
            .clk        (clk),
            .read_addr  (src_addr),
            .read_data  (bank_rd[b]),
            .write_en   (is_cur ? host_we : write_valid),
            .write_addr (is_cur ? src_addr : wr_addr_q),
            .write_data (is_cur ? host_data : wr_data_q)
        );
    end

    assign rd_word = bank_rd[buf_sel];

endmodule

/* rtl/host_port.sv */
`timescale 1ns/10ps
`include "lbm_params.svh"

module host_port (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 busy,
    input  logic                 load_en,
    input  lbm_pkg::dir_t        load_dir,
    input  lbm_pkg::dist_t       load_data,
    input  logic                 rd_en,
    input  lbm_pkg::dir_t        rd_dir,
    input  lbm_pkg::dist_t       lane_words [`LBM_DIRS],
    output logic [`LBM_DIRS-1:0] lane_we,
    output lbm_pkg::dist_t       lane_data,
    output lbm_pkg::dist_t       rd_data,
    output logic                 rd_valid
);

    lbm_pkg::dir_t rd_dir_q;

    // one-hot lane enable, loads dropped during a step
    always_comb
    begin
        lane_we = '0;
        if (load_en && !busy && (int'(load_dir) < `LBM_DIRS))
            lane_we[load_dir] = 1'b1;
    end

    assign lane_data = load_data;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            rd_valid <= 1'b0;
            rd_dir_q <= lbm_pkg::DIR_REST;
        end
        else
        begin
            rd_valid <= rd_en && !busy;
            if (rd_en)
                rd_dir_q <= rd_dir;
        end
    end

    // bank data arrives the cycle after the request
    assign rd_data = (int'(rd_dir_q) < `LBM_DIRS) ? lane_words[rd_dir_q] : '0;

endmodule

/* rtl/lbm_top.sv */
`timescale 1ns/10ps
`include "lbm_params.svh"

module lbm_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start,
    output logic                  busy,
    output logic                  done,
    input  logic [`LBM_DEPTH-1:0] barriers,
    input  logic                  load_en,
    input  lbm_pkg::dir_t         load_dir,
    input  lbm_pkg::addr_t        load_addr,
    input  lbm_pkg::dist_t        load_data,
    input  logic                  rd_en,
    input  lbm_pkg::dir_t         rd_dir,
    input  lbm_pkg::addr_t        rd_addr,
    output lbm_pkg::dist_t        rd_data,
    output logic                  rd_valid
);

    lbm_pkg::addr_t        host_addr;
    lbm_pkg::addr_t        src_addr;
    lbm_pkg::col_t         src_col;
    lbm_pkg::row_t         src_row;
    logic                  read_valid;
    logic                  write_valid;
    logic                  buf_sel;
    logic [`LBM_DIRS-1:0]  lane_we;
    lbm_pkg::dist_t        lane_data;
    lbm_pkg::dist_t        lane_words [`LBM_DIRS];

    // reads and loads share one address into the banks
    assign host_addr = rd_en ? rd_addr : load_addr;

    sweep_ctrl i_sweep_ctrl (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .host_addr   (host_addr),
        .busy        (busy),
        .done        (done),
        .src_addr    (src_addr),
        .src_col     (src_col),
        .src_row     (src_row),
        .read_valid  (read_valid),
        .write_valid (write_valid),
        .buf_sel     (buf_sel)
    );

    host_port i_host_port (
        .clk        (clk),
        .rst        (rst),
        .busy       (busy),
        .load_en    (load_en),
        .load_dir   (load_dir),
        .load_data  (load_data),
        .rd_en      (rd_en),
        .rd_dir     (rd_dir),
        .lane_words (lane_words),
        .lane_we    (lane_we),
        .lane_data  (lane_data),
        .rd_data    (rd_data),
        .rd_valid   (rd_valid)
    );

    for (genvar d = 0; d < `LBM_DIRS; d++)
    begin : g_lane
        // reflection source for barrier cells
        localparam int OPP = int'(lbm_pkg::opposite_dir(lbm_pkg::dir_t'(d)));

        stream_lane #(
            .DIR (lbm_pkg::dir_t'(d))
        ) i_stream_lane (
            .clk         (clk),
            .rst         (rst),
            .barriers    (barriers),
            .src_addr    (src_addr),
            .src_col     (src_col),
            .src_row     (src_row),
            .read_valid  (read_valid),
            .write_valid (write_valid),
            .buf_sel     (buf_sel),
            .opp_word    (lane_words[OPP]),
            .host_we     (lane_we[d]),
            .host_data   (lane_data),
            .rd_word     (lane_words[d])
        );
    end

endmodule

/* testbench/lbm_sva.sv */
`timescale 1ns/10ps
`include "lbm_params.svh"

module lbm_sva (
    input logic clk,
    input logic rst,
    input logic start,
    input logic busy,
    input logic done,
    input logic rd_en,
    input logic rd_valid
);

    int failure_count;
    // busy cycles of the running step, held until the edge that sees busy low
    int busy_cycles;

    initial
    begin
        failure_count = 0;
    end

    always @(posedge clk or posedge rst)
    begin
        if (rst)
            busy_cycles <= 0;
        else if (busy)
            busy_cycles <= busy_cycles + 1;
        else
            busy_cycles <= 0;
    end

    done_one_cycle: assert property (@(posedge clk) disable iff (rst) done |=> !done)
    else
    begin
        $error("done stayed high for more than one cycle");
        failure_count++;
    end

    done_when_idle: assert property (@(posedge clk) disable iff (rst) done |-> !busy)
    else
    begin
        $error("done was high while busy was high");
        failure_count++;
    end

    start_sets_busy: assert property (@(posedge clk) disable iff (rst)
        (start && !busy) |=> busy)
    else
    begin
        $error("busy did not rise after an accepted start");
        failure_count++;
    end

    // a step keeps busy high for the sweep plus two pipeline cycles
    busy_length: assert property (@(posedge clk) disable iff (rst)
        $fell(busy) |-> (busy_cycles == `LBM_DEPTH + 2))
    else
    begin
        $error("busy length was %0d cycles", busy_cycles);
        failure_count++;
    end

    read_answered: assert property (@(posedge clk) disable iff (rst)
        (rd_en && !busy) |=> rd_valid)
    else
    begin
        $error("rd_valid missing one cycle after an accepted rd_en");
        failure_count++;
    end

    read_requested: assert property (@(posedge clk) disable iff (rst)
        rd_valid |-> $past(rd_en && !busy))
    else
    begin
        $error("rd_valid without an accepted rd_en in the cycle before");
        failure_count++;
    end

endmodule

bind lbm_top lbm_sva i_lbm_sva (
    .clk      (clk),
    .rst      (rst),
    .start    (start),
    .busy     (busy),
    .done     (done),
    .rd_en    (rd_en),
    .rd_valid (rd_valid)
);

/* testbench/lbm_tb.sv */
`timescale 1ns/10ps
`include "lbm_params.svh"

module lbm_tb;

    // five tests take roughly 1300 cycles, the limit leaves a wide margin
    localparam int TIMEOUT_CYCLES = 5000;
    localparam int MID_CELL = 5;
    // column and row steps in the order rest, n, ne, e, se, s, sw, w, nw
    localparam int DX [`LBM_DIRS] = '{0, 0, 1, 1, 1, 0, -1, -1, -1};
    localparam int DY [`LBM_DIRS] = '{0, -1, -1, 0, 1, 1, 1, 0, -1};

    logic                  clk;
    logic                  rst;
    logic                  start;
    logic                  busy;
    logic                  done;
    logic [`LBM_DEPTH-1:0] barriers;
    logic                  load_en;
    lbm_pkg::dir_t         load_dir;
    lbm_pkg::addr_t        load_addr;
    lbm_pkg::dist_t        load_data;
    logic                  rd_en;
    lbm_pkg::dir_t         rd_dir;
    lbm_pkg::addr_t        rd_addr;
    lbm_pkg::dist_t        rd_data;
    logic                  rd_valid;

    // expected contents of the current buffer
    lbm_pkg::dist_t model [`LBM_DIRS][`LBM_DEPTH];
    lbm_pkg::dist_t expect_q [$];
    string          label_q [$];
    logic [15:0]    lfsr_state;
    logic           rd_issued_q;
    int             cycle_count;
    int             error_count;
    int             test_errors;
    int             tests_run;
    int             tests_failed;
    string          test_name;

    lbm_top i_lbm_top (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .busy      (busy),
        .done      (done),
        .barriers  (barriers),
        .load_en   (load_en),
        .load_dir  (load_dir),
        .load_addr (load_addr),
        .load_data (load_data),
        .rd_en     (rd_en),
        .rd_dir    (rd_dir),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .rd_valid  (rd_valid)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #50 clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
            v = {v[30:0], lfsr_bit()};
        return v;
    endfunction

    function automatic int wrap(int v, int n);
        return (v + n) % n;
    endfunction

    // the direction whose step cancels the step of d
    function automatic int reverse_of(int d);
        for (int e = 0; e < `LBM_DIRS; e++)
            if (DX[e] == -DX[d] && DY[e] == -DY[d])
                return e;
        return d;
    endfunction

    // value that one step leaves in direction d at target cell t
    function automatic lbm_pkg::dist_t stream_ref(int d, int t, logic [`LBM_DEPTH-1:0] bar);
        int col;
        int row;
        int src;
        col = wrap(t % `LBM_WIDTH - DX[d], `LBM_WIDTH);
        row = wrap(t / `LBM_WIDTH - DY[d], `LBM_HEIGHT);
        src = row * `LBM_WIDTH + col;
        if (bar[t])
            return '0;
        if (bar[src])
            return model[reverse_of(d)][src];
        return model[d][src];
    endfunction

    task automatic step_model();
        lbm_pkg::dist_t next [`LBM_DIRS][`LBM_DEPTH];
        for (int d = 0; d < `LBM_DIRS; d++)
            for (int t = 0; t < `LBM_DEPTH; t++)
                next[d][t] = stream_ref(d, t, barriers);
        model = next;
    endtask

    task automatic check_value(string what, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("FAIL %s (%s) expected %0h actual %0h", test_name, what, expected, actual);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic note_failure(string msg);
        $display("error in test %s: %s", test_name, msg);
        error_count++;
        test_errors++;
    endtask

    task automatic begin_test(string name);
        test_name = name;
        test_errors = 0;
        tests_run++;
    endtask

    task automatic end_test();
        if (expect_q.size() != 0)
            note_failure("some read requests never returned data");
        if (test_errors == 0)
            $display("test %s passed", test_name);
        else
        begin
            $display("test %s had %0d errors", test_name, test_errors);
            tests_failed++;
        end
    endtask

    task automatic release_bus();
        @(negedge clk);
        load_en = 1'b0;
        rd_en = 1'b0;
    endtask

    task automatic load_word(int d, int c, lbm_pkg::dist_t value);
        @(negedge clk);
        load_en = 1'b1;
        load_dir = lbm_pkg::dir_t'(d);
        load_addr = lbm_pkg::addr_t'(c);
        load_data = value;
        model[d][c] = value;
    endtask

    task automatic read_word(int d, int c, lbm_pkg::dist_t expected);
        @(negedge clk);
        rd_en = 1'b1;
        rd_dir = lbm_pkg::dir_t'(d);
        rd_addr = lbm_pkg::addr_t'(c);
        expect_q.push_back(expected);
        label_q.push_back($sformatf("dir %0d cell %0d", d, c));
    endtask

    task automatic load_random_field();
        for (int d = 0; d < `LBM_DIRS; d++)
            for (int c = 0; c < `LBM_DEPTH; c++)
                load_word(d, c, lbm_pkg::dist_t'(rand_bits(`LBM_DATA_WIDTH)));
        release_bus();
    endtask

    task automatic read_all();
        for (int d = 0; d < `LBM_DIRS; d++)
            for (int c = 0; c < `LBM_DEPTH; c++)
                read_word(d, c, model[d][c]);
        release_bus();
        @(negedge clk);
    endtask

    // latency counts cycles from the start edge to the done cycle
    task automatic run_step(logic poke_busy, output int latency);
        latency = 0;
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        // one edge has passed since the start edge
        latency = 1;
        while (!done && latency < 4 * `LBM_DEPTH)
        begin
            @(negedge clk);
            latency++;
            start = poke_busy && (latency == 4);
        end
        start = 1'b0;
        if (!done)
            note_failure("done never arrived after start");
        step_model();
    endtask

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // reads are only issued between steps
    always @(posedge clk)
        rd_issued_q <= rd_en;

    // outputs are registered, so mid-cycle sampling sees settled values
    always @(negedge clk)
    begin : compare_reads
        lbm_pkg::dist_t want;
        string what;
        if (!rst)
        begin
            check_value("rd_valid timing", 32'(rd_issued_q), 32'(rd_valid));
            if (rd_valid && expect_q.size() == 0)
                note_failure("read data arrived with no read outstanding");
            else if (rd_valid)
            begin
                want = expect_q.pop_front();
                what = label_q.pop_front();
                check_value(what, 32'(want), 32'(rd_data));
            end
        end
    end

    initial
    begin : run_tests
        int latency;
        rst = 1'b1;
        start = 1'b0;
        barriers = '0;
        load_en = 1'b0;
        load_dir = lbm_pkg::DIR_REST;
        load_addr = '0;
        load_data = '0;
        rd_en = 1'b0;
        rd_dir = lbm_pkg::DIR_REST;
        rd_addr = '0;
        lfsr_state = 16'd52;
        rd_issued_q = 1'b0;
        cycle_count = 0;
        error_count = 0;
        test_errors = 0;
        tests_run = 0;
        tests_failed = 0;
        test_name = "setup";
        repeat (8) @(negedge clk);
        rst = 1'b0;

        begin_test("reset_state");
        @(negedge clk);
        check_value("busy", 0, 32'(busy));
        check_value("done", 0, 32'(done));
        check_value("rd_valid", 0, 32'(rd_valid));
        end_test();

        begin_test("load_readback");
        load_random_field();
        read_all();
        end_test();

        begin_test("free_streaming");
        barriers = '0;
        load_random_field();
        run_step(1'b0, latency);
        check_value("done latency", `LBM_DEPTH + 3, latency);
        read_all();
        end_test();

        begin_test("bounce_back");
        barriers = `LBM_DEPTH'(1) << MID_CELL;
        load_random_field();
        run_step(1'b0, latency);
        read_all();
        // a barrier cell keeps nothing after a step
        for (int d = 0; d < `LBM_DIRS; d++)
            read_word(d, MID_CELL, '0);
        release_bus();
        @(negedge clk);
        end_test();

        begin_test("several_steps");
        barriers = `LBM_DEPTH'(rand_bits(`LBM_DEPTH) & rand_bits(`LBM_DEPTH));
        load_random_field();
        run_step(1'b0, latency);
        run_step(1'b1, latency);
        run_step(1'b0, latency);
        repeat (2) @(negedge clk);
        check_value("busy after three steps", 0, 32'(busy));
        read_all();
        if (i_lbm_top.i_lbm_sva.failure_count != 0)
            note_failure("bound assertions reported failures");
        end_test();

        $display("tests run %0d, tests failed %0d, checks failed %0d",
                 tests_run, tests_failed, error_count);
        if (error_count == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

/* lbm.f */
+incdir+rtl
rtl/lbm_pkg.sv
rtl/lattice_ram.sv
rtl/sweep_ctrl.sv
rtl/stream_lane.sv
rtl/host_port.sv
rtl/lbm_top.sv
testbench/lbm_sva.sv
testbench/lbm_tb.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  make test   build the testbench with Verilator and run it"
	@echo "  make clean  remove the Verilator build directory"
	@echo "  make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module lbm_tb -f lbm.f --Mdir obj_dir
	@out=$$(./obj_dir/Vlbm_tb); echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir
